/* spi_msg_pkg.sv */
`default_nettype none

package spi_msg_pkg;

    // ====================
    // Lengths
    // ====================
    localparam int MSG_LEN  = 64;
    localparam int RESP_LEN = 64;
    localparam int ARG_LEN  = 56;

    typedef logic [7:0] msg_type_t;

    localparam int MSG_RESP_BIT = 7; // Set when the command answers

    // Command codes
    localparam msg_type_t MSG_NOP     = 8'h00;
    localparam msg_type_t MSG_LED_SET = 8'h01;
    localparam msg_type_t MSG_ECHO    = 8'h80;
    localparam msg_type_t MSG_READOUT = 8'h81;

    // ====================
    // Argument views
    // ====================
    typedef struct packed {
        logic [51:0] pad;
        logic [3:0]  value;     // LED state
    } led_arg_t;

    typedef struct packed {
        logic [39:0] pad;
        logic [15:0] count;     // Words to stream back
    } readout_arg_t;

    // One argument word, read per command
    typedef union packed {
        logic [ARG_LEN-1:0] echo;
        led_arg_t           led;
        readout_arg_t       readout;
    } msg_arg_u;

    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_u  arg;
    } spi_msg_t;

    typedef struct packed {
        msg_type_t          resp_type;  // Copy of the message type
        logic [ARG_LEN-1:0] payload;
    } spi_resp_t;

endpackage

`default_nettype wire

/* readout_pkg.sv */
`default_nettype none

package readout_pkg;

    localparam int PIXEL_BITS = 16;

    // Raw pixel word from the image side
    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // Pixel source to FIFO
    typedef struct packed {
        logic   valid;  // Spends one credit
        pixel_t data;
    } pixel_in_t;

endpackage

`default_nettype wire

/* spi_msg_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_msg_rx (
    input  wire logic                  img_clk,
    input  wire logic                  spi_rst_,
    input  wire logic                  spi_data_in,
    input  wire logic                  link_busy,
    output spi_msg_pkg::spi_msg_t      msg,
    output logic                       msg_valid
);

    localparam int CNT_W = $clog2(spi_msg_pkg::MSG_LEN);

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_t;

    rx_state_t              state;
    logic [CNT_W-1:0]       bit_cnt;
    logic [spi_msg_pkg::MSG_LEN-1:0] msg_shreg;

    assign msg = spi_msg_pkg::spi_msg_t'(msg_shreg);

    // Message bits arrive MSB first
    always_ff @(posedge img_clk) begin
        if (state == RX_SHIFT) begin
            msg_shreg <= {msg_shreg[spi_msg_pkg::MSG_LEN-2:0], spi_data_in};
        end
    end

    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Line belongs to the transmitter while busy
                    if (spi_data_in && !link_busy && !msg_valid) begin
                        bit_cnt <= '0;
                        state   <= RX_SHIFT;
                    end
                end
                RX_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(spi_msg_pkg::MSG_LEN - 1)) begin
                        msg_valid <= 1'b1;  // Last bit taken
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* cmd_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_exec (
    input  wire logic                  img_clk,
    input  wire logic                  spi_rst_,
    input  wire spi_msg_pkg::spi_msg_t msg,
    input  wire logic                  msg_valid,
    output logic [3:0]                 led,
    output spi_msg_pkg::spi_resp_t     resp,
    output logic                       resp_en,
    output logic [15:0]                readout_count,
    output logic                       start
);

    logic known_type;

    always_comb begin
        case (msg.msg_type)
            spi_msg_pkg::MSG_NOP,
            spi_msg_pkg::MSG_LED_SET,
            spi_msg_pkg::MSG_ECHO,
            spi_msg_pkg::MSG_READOUT: known_type = 1'b1;
            default:                  known_type = 1'b0;
        endcase
    end

    // ====================
    // Response word
    // ====================
    always_ff @(posedge img_clk) begin
        if (msg_valid) begin
            resp.resp_type <= msg.msg_type;
            if (msg.msg_type == spi_msg_pkg::MSG_ECHO) begin
                resp.payload <= msg.arg.echo;
            end else begin
                resp.payload <= '0; // Readout answers with an empty payload
            end
        end
    end

    // ====================
    // Decode
    // ====================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led           <= 4'h0;
            resp_en       <= 1'b0;
            readout_count <= '0;
            start         <= 1'b0;
        end else begin
            start <= msg_valid;   // Every message kicks the transmitter
            if (msg_valid) begin
                // Unknown codes fall back to Nop
                resp_en       <= known_type && msg.msg_type[spi_msg_pkg::MSG_RESP_BIT];
                readout_count <= '0;
                case (msg.msg_type)
                    spi_msg_pkg::MSG_LED_SET: begin
                        led <= msg.arg.led.value;
                    end
                    spi_msg_pkg::MSG_READOUT: begin
                        readout_count <= msg.arg.readout.count;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* readout_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module readout_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic                  img_clk,
    input  wire logic                  spi_rst_,
    input  wire readout_pkg::pixel_in_t pixel_in,
    output logic                       pixel_credit,
    input  wire logic                  pop,
    output readout_pkg::pixel_t        head,
    output logic                       not_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    readout_pkg::pixel_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   fill;    // 0 .. FIFO_DEPTH

    assign head      = mem[rd_ptr];
    assign not_empty = (fill != '0);

    // No full check, the credit count keeps the source in bounds
    always_ff @(posedge img_clk) begin
        if (pixel_in.valid) begin
            mem[wr_ptr] <= pixel_in.data;
        end
    end

    // ====================
    // Pointers and fill
    // ====================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            pixel_credit <= 1'b0;
        end else begin
            pixel_credit <= pop;    // Slot freed, hand it back

            if (pixel_in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({pixel_in.valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

/* spi_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_tx #(
    parameter int TURNAROUND = 6
) (
    input  wire logic                  img_clk,
    input  wire logic                  spi_rst_,
    input  wire spi_msg_pkg::spi_resp_t resp,
    input  wire logic                  resp_en,
    input  wire logic [15:0]           readout_count,
    input  wire logic                  start,
    input  wire readout_pkg::pixel_t   head,
    input  wire logic                  not_empty,
    output logic                       pop,
    output logic                       spi_data_out,
    output logic                       spi_data_oe,
    output logic                       link_busy
);

    localparam int TA_W  = $clog2(TURNAROUND + 1);
    localparam int BIT_W = $clog2(spi_msg_pkg::RESP_LEN);
    localparam int PAD_W = spi_msg_pkg::RESP_LEN - readout_pkg::PIXEL_BITS;

    typedef enum logic [1:0] {
        TX_TURN,
        TX_RESP,
        TX_WORD_WAIT,
        TX_WORD
    } tx_state_t;

    tx_state_t                         state;
    logic                              busy;
    logic [TA_W-1:0]                   ta_cnt;
    logic [BIT_W-1:0]                  bit_cnt;
    logic [15:0]                       words_left;
    logic [spi_msg_pkg::RESP_LEN-1:0]  tx_shreg;
    logic                              last_bit;
    logic                              load_resp;
    logic                              load_word;

    assign last_bit  = (bit_cnt == '0) && (state == TX_RESP || state == TX_WORD);
    assign load_resp = busy && !start && (state == TX_TURN) && (ta_cnt == '0) && resp_en;
    // Next word goes out straight after the previous one if the FIFO has it
    assign load_word = busy && not_empty && (words_left != '0)
                     && (state == TX_WORD_WAIT || last_bit);

    assign pop          = load_word;
    assign spi_data_out = tx_shreg[spi_msg_pkg::RESP_LEN-1];
    assign link_busy    = busy | start;

    // ====================
    // Shift register
    // ====================
    always_ff @(posedge img_clk) begin
        if (load_resp) begin
            tx_shreg <= resp;
        end else if (load_word) begin
            tx_shreg <= {head, {PAD_W{1'b0}}};  // Pixel sits in the top bits
        end else begin
            tx_shreg <= tx_shreg << 1;
        end
    end

    // ====================
    // Control
    // ====================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state       <= TX_TURN;
            busy        <= 1'b0;
            spi_data_oe <= 1'b0;
            ta_cnt      <= '0;
            bit_cnt     <= '0;
            words_left  <= '0;
        end else if (start) begin
            busy        <= 1'b1;
            state       <= TX_TURN;
            spi_data_oe <= 1'b0;
            words_left  <= readout_count;
            // One extra idle cycle before release when nothing is sent
            ta_cnt      <= resp_en ? TA_W'(TURNAROUND - 2) : TA_W'(TURNAROUND - 1);
        end else if (busy) begin
            case (state)
                TX_TURN: begin
                    if (ta_cnt != '0) begin
                        ta_cnt <= ta_cnt - 1'b1;
                    end else if (resp_en) begin
                        bit_cnt     <= BIT_W'(spi_msg_pkg::RESP_LEN - 1);
                        spi_data_oe <= 1'b1;
                        state       <= TX_RESP;
                    end else begin
                        busy <= 1'b0;
                    end
                end
                TX_RESP, TX_WORD: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (last_bit) begin
                        spi_data_oe <= 1'b0;
                        if (words_left == '0) begin
                            busy <= 1'b0;
                        end else begin
                            state <= TX_WORD_WAIT;  // Stall until the FIFO fills
                        end
                    end
                end
                default: begin
                end
            endcase

            if (load_word) begin
                bit_cnt     <= BIT_W'(readout_pkg::PIXEL_BITS - 1);
                words_left  <= words_left - 1'b1;
                spi_data_oe <= 1'b1;
                state       <= TX_WORD;
            end
        end
    end

endmodule

`default_nettype wire

/* ice_app.sv */
`timescale 1ns/10ps
`default_nettype none

module ice_app #(
    parameter int FIFO_DEPTH = 16,  // Power of two
    parameter int TURNAROUND = 6    // At least 2
) (
    input  wire logic                  img_clk,
    input  wire logic                  spi_rst_,
    input  wire logic                  spi_data_in,
    output logic                       spi_data_out,
    output logic                       spi_data_oe,
    output logic [3:0]                 led,
    input  wire readout_pkg::pixel_in_t pixel_in,
    output logic                       pixel_credit
);

    spi_msg_pkg::spi_msg_t  msg;
    logic                   msg_valid;
    spi_msg_pkg::spi_resp_t resp;
    logic                   resp_en;
    logic [15:0]            readout_count;
    logic                   start;
    logic                   link_busy;
    logic                   pop;
    readout_pkg::pixel_t    head;
    logic                   not_empty;

    // ====================
    // Command path
    // ====================
    spi_msg_rx spi_msg_rx_inst (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .spi_data_in (spi_data_in),
        .link_busy   (link_busy),
        .msg         (msg),
        .msg_valid   (msg_valid)
    );

    cmd_exec cmd_exec_inst (
        .img_clk       (img_clk),
        .spi_rst_      (spi_rst_),
        .msg           (msg),
        .msg_valid     (msg_valid),
        .led           (led),
        .resp          (resp),
        .resp_en       (resp_en),
        .readout_count (readout_count),
        .start         (start)
    );

    // ====================
    // Readout path
    // ====================
    readout_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) readout_fifo_inst (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .pixel_in     (pixel_in),
        .pixel_credit (pixel_credit),
        .pop          (pop),
        .head         (head),
        .not_empty    (not_empty)
    );

    spi_tx #(
        .TURNAROUND (TURNAROUND)
    ) spi_tx_inst (
        .img_clk       (img_clk),
        .spi_rst_      (spi_rst_),
        .resp          (resp),
        .resp_en       (resp_en),
        .readout_count (readout_count),
        .start         (start),
        .head          (head),
        .not_empty     (not_empty),
        .pop           (pop),
        .spi_data_out  (spi_data_out),
        .spi_data_oe   (spi_data_oe),
        .link_busy     (link_busy)
    );

endmodule

`default_nettype wire

/* tb_ice_app.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ice_app;

    localparam int FIFO_DEPTH     = 16;
    localparam int TURNAROUND     = 6;
    localparam int READOUT_WORDS  = 40;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] LFSR_SEED = 32'd95538;

    logic                   img_clk;
    logic                   spi_rst_;
    logic                   spi_data_in;
    logic                   spi_data_out;
    logic                   spi_data_oe;
    logic [3:0]             led;
    readout_pkg::pixel_in_t pixel_in;
    logic                   pixel_credit;

    logic [31:0]         lfsr_state = LFSR_SEED;
    logic                rx_bits[$];            // Bits seen while oe is high
    readout_pkg::pixel_t sent_words[$];
    int  credits = FIFO_DEPTH;
    int  credit_returns = 0;
    int  sent_count = 0;
    int  readout_bits = 0;                      // Header bits included
    int  feed_mode = 0;                         // 0 off, 1 slow, 2 every cycle
    int  feed_limit = 0;
    int  mismatch_cnt = 0;
    int  fail_cnt = 0;
    int  cycle_cnt = 0;
    logic sending = 1'b0;
    logic readout_started = 1'b0;

    ice_app #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .TURNAROUND (TURNAROUND)
    ) ice_app_inst (
        .img_clk      (img_clk),
        .spi_rst_     (spi_rst_),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .spi_data_oe  (spi_data_oe),
        .led          (led),
        .pixel_in     (pixel_in),
        .pixel_credit (pixel_credit)
    );

    always #10 img_clk = ~img_clk;

    // ====================
    // Helpers
    // ====================
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [63:0] collected_word(input int first, input int width);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < width; i++) begin
            w = {w[62:0], rx_bits[first + i]};  // MSB arrives first
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        mismatch_cnt++;
        $display("MISMATCH %s expected=%0h actual=%0h", name, exp, act);
    endtask

    task automatic next_cycle();
        @(posedge img_clk);
        #2;
    endtask

    // Start bit, then 64 bits MSB first
    task automatic send_msg(input logic [7:0] mtype, input logic [55:0] arg);
        logic [63:0] word;
        word = {mtype, arg};
        sending = 1'b1;
        spi_data_in = 1'b1;
        next_cycle();
        for (int i = 63; i >= 0; i--) begin
            spi_data_in = word[i];
            next_cycle();
        end
        spi_data_in = 1'b0;
        sending = 1'b0;
    endtask

    // Latency counts edges from launch of the last message bit
    task automatic read_response(input int n_bits, output int latency, output int stalls);
        int got;
        latency = 1;
        stalls = 0;
        got = 0;
        rx_bits.delete();
        @(negedge img_clk);
        while (!spi_data_oe && latency < 200) begin
            latency++;
            @(negedge img_clk);
        end
        if (!spi_data_oe) begin
            fail_cnt++;
            $display("no response appeared on the data line");
            n_bits = 0;
        end
        while (got < n_bits) begin
            if (spi_data_oe) begin
                rx_bits.push_back(spi_data_out);
                got++;
            end else begin
                stalls++;
            end
            if (got < n_bits) begin
                @(negedge img_clk);
            end
        end
        next_cycle();
    endtask

    task automatic expect_silence(input string name);
        repeat (TURNAROUND + 6) begin
            @(negedge img_clk);
            assert (!spi_data_oe) else begin
                fail_cnt++;
                $display("%s drove the data line though it has no response", name);
            end
        end
        next_cycle();
    endtask

    task automatic echo_test(input string name);
        logic [55:0] payload;
        int          latency;
        int          stalls;
        payload = 56'(random_bits(56));
        send_msg(spi_msg_pkg::MSG_ECHO, payload);
        read_response(64, latency, stalls);
        assert (latency == TURNAROUND + 2)
            else report_mismatch({name, " latency"}, TURNAROUND + 2, latency);
        assert (collected_word(0, 64) == {8'h80, payload})
            else report_mismatch(name, {8'h80, payload}, collected_word(0, 64));
        repeat (3) next_cycle();
    endtask

    // ====================
    // Pixel source
    // ====================
    initial begin : pixel_source
        logic                go;
        readout_pkg::pixel_t word;
        pixel_in = '0;
        forever begin
            @(posedge img_clk);
            #1;
            go = 1'b0;
            if (feed_mode != 0 && credits > 0 && sent_count < feed_limit) begin
                go = (feed_mode == 2) || (random_bits(5) == '0);   // Slow, about 1 in 32
            end
            word = go ? 16'(random_bits(16)) : '0;
            if (go) begin
                credits--;
                sent_count++;
                sent_words.push_back(word);
            end
            #1;
            pixel_in.valid = go;
            pixel_in.data  = word;
            @(negedge img_clk);
            if (pixel_credit) begin
                credits++;
                credit_returns++;
            end
        end
    end

    always @(negedge img_clk) begin
        if (readout_started && spi_data_oe) begin
            readout_bits++;
        end
    end

    credit_range: assert property (@(negedge img_clk) disable iff (!spi_rst_)
        credits >= 0 && credits <= FIFO_DEPTH)
        else begin
            fail_cnt++;
            $display("pixel source holds %0d credits, outside 0..%0d", credits, FIFO_DEPTH);
        end

    // A word has left the FIFO once its first bit is on the line
    fill_bound: assert property (@(negedge img_clk) disable iff (!spi_rst_)
        sent_count - (readout_bits > 64 ? (readout_bits - 64 + 15) / 16 : 0) <= FIFO_DEPTH)
        else begin
            fail_cnt++;
            $display("more pixel words outstanding than the FIFO can hold");
        end

    no_idle_credit: assert property (@(negedge img_clk) disable iff (!spi_rst_)
        !readout_started |-> !pixel_credit)
        else begin
            fail_cnt++;
            $display("credit returned although no word was read out");
        end

    quiet_rx: assert property (@(negedge img_clk) disable iff (!spi_rst_)
        sending |-> !spi_data_oe)
        else begin
            fail_cnt++;
            $display("data line driven while the host sends a message");
        end

    // ====================
    // Watchdog
    // ====================
    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge img_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, test sequence did not finish", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================
    initial begin : main_seq
        logic [3:0]  led_val;
        logic [3:0]  led_before;
        logic [39:0] pad;
        int          latency;
        int          stalls;
        img_clk     = 1'b0;
        spi_rst_    = 1'b0;
        spi_data_in = 1'b0;
        repeat (8) next_cycle();
        spi_rst_ = 1'b1;
        next_cycle();

        assert (!spi_data_oe) else report_mismatch("reset oe", 0, spi_data_oe);
        assert (led == 4'h0) else report_mismatch("reset led", 0, led);

        echo_test("echo 1");
        echo_test("echo 2");

        repeat (2) begin
            led_val = 4'(random_bits(4));
            send_msg(spi_msg_pkg::MSG_LED_SET, {52'(random_bits(52)), led_val});
            expect_silence("led set");
            assert (led == led_val) else report_mismatch("led set", led_val, led);
        end

        // Nop and unknown codes leave the LEDs alone
        led_before = led;
        send_msg(spi_msg_pkg::MSG_NOP, 56'(random_bits(56)));
        expect_silence("nop");
        send_msg(8'h42, 56'(random_bits(56)));
        expect_silence("unknown 42");
        send_msg(8'hC3, 56'(random_bits(56)));
        expect_silence("unknown c3");
        assert (led == led_before) else report_mismatch("nop led", led_before, led);
        echo_test("echo after nop");

        // Fill the FIFO, then feed slowly so the transmitter starves
        feed_limit = READOUT_WORDS;
        feed_mode  = 2;
        while (sent_count < FIFO_DEPTH) begin
            next_cycle();
        end
        assert (credits == 0) else report_mismatch("prefill credits", 0, credits);
        feed_mode       = 1;
        readout_started = 1'b1;
        pad = 40'(random_bits(40));
        send_msg(spi_msg_pkg::MSG_READOUT, {pad, 16'(READOUT_WORDS)});
        read_response(64 + 16 * READOUT_WORDS, latency, stalls);
        assert (latency == TURNAROUND + 2)
            else report_mismatch("readout latency", TURNAROUND + 2, latency);
        assert (collected_word(0, 64) == {8'h81, 56'h0})
            else report_mismatch("readout header", {8'h81, 56'h0}, collected_word(0, 64));
        for (int k = 0; k < READOUT_WORDS; k++) begin
            assert (collected_word(64 + 16 * k, 16) == sent_words[k])
                else report_mismatch($sformatf("readout word %0d", k), sent_words[k],
                                     collected_word(64 + 16 * k, 16));
        end
        assert (stalls > 0) else begin
            fail_cnt++;
            $display("transmitter never waited on an empty FIFO");
        end
        feed_mode = 0;
        repeat (4) next_cycle();
        assert (credit_returns == READOUT_WORDS)
            else report_mismatch("credit returns", READOUT_WORDS, credit_returns);
        assert (credits == FIFO_DEPTH) else report_mismatch("final credits", FIFO_DEPTH, credits);
        readout_started = 1'b0;
        echo_test("echo after readout");

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
spi_msg_pkg.sv
readout_pkg.sv
spi_msg_rx.sv
cmd_exec.sv
readout_fifo.sv
spi_tx.sv
ice_app.sv
tb_ice_app.sv
